/* common/spi_pkg.sv */
// shared widths, encodings and the request record for the SPI master, imported by every RTL file
package spi_pkg;

  // command, address and data all travel as one 32-bit word
  localparam int word_w = 32;

  // transfer lengths are counted in bits
  localparam int len_w = 16;
  localparam int field_len_w = 6;

  localparam int div_w = 8;
  localparam int num_cs = 4;

  // bits moved per serial clock in quad operation
  localparam int quad_lanes = 4;

  typedef enum logic [1:0] {
    op_read       = 2'b00,
    op_write      = 2'b01,
    op_quad_read  = 2'b10,
    op_quad_write = 2'b11
  } spi_op_e;

  // pad direction as seen by the IO cells
  typedef enum logic [1:0] {
    mode_std      = 2'b00,
    mode_quad_out = 2'b01,
    mode_quad_in  = 2'b10
  } spi_mode_e;

  typedef enum logic [2:0] {
    ph_idle,
    ph_cmd,
    ph_addr,
    ph_data_out,
    ph_data_in
  } spi_phase_e;

  // cmd and addr are left aligned, a field of length L uses bits 31 down to 32-L
  typedef struct packed {
    spi_op_e                op;
    logic [word_w-1:0]      cmd;
    logic [field_len_w-1:0] cmd_len;
    logic [word_w-1:0]      addr;
    logic [field_len_w-1:0] addr_len;
    logic [len_w-1:0]       data_len;
    logic [num_cs-1:0]      cs_mask;
    logic [div_w-1:0]       clk_div;
  } spi_req_t;

endpackage

/* rtl/spi_clkgen.sv */
// serial clock timer, toggles sclk every clk_div+1 cycles while enabled and flags each edge
module spi_clkgen
  import spi_pkg::*;
(
  input  logic             clk,
  input  logic             rstn,
  input  logic             en,
  input  logic [div_w-1:0] clk_div,
  output logic             sclk,
  output logic             sclk_rise,
  output logic             sclk_fall
);

  logic [div_w-1:0] cnt;
  logic             tick;

  // the strobes mark the cycle whose closing edge moves sclk
  assign tick      = en && (cnt == '0);
  assign sclk_rise = tick && !sclk;
  assign sclk_fall = tick && sclk;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      cnt  <= '0;
      sclk <= 1'b0;
    end
    else if (!en)
    begin
      // parked low with a full half period ready for the restart
      cnt  <= clk_div;
      sclk <= 1'b0;
    end
    else if (tick)
    begin
      cnt  <= clk_div;
      sclk <= !sclk;
    end
    else
      cnt <= cnt - 1'b1;
  end

endmodule

/* spi_engine/spi_tx_shift.sv */
// outbound shifter, presents bits on sdo and advances on sclk falling strobes, one or four lanes
module spi_tx_shift
  import spi_pkg::*;
(
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  load,
  input  logic [len_w-1:0]      bits,
  input  logic [word_w-1:0]     word,
  input  logic                  word_valid,
  input  logic                  quad,
  input  logic                  tx_edge,
  output logic                  word_ready,
  output logic [quad_lanes-1:0] sdo,
  output logic                  done,
  output logic                  clk_en
);

  logic [word_w-1:0] shreg;
  logic [len_w-1:0]  cnt;
  logic [len_w-1:0]  word_left;
  logic [len_w-1:0]  step;
  logic              waiting;
  logic              shift;

  assign step       = quad ? len_w'(quad_lanes) : len_w'(1);
  assign shift      = tx_edge && (cnt != '0) && !waiting;
  assign word_ready = load || waiting;
  // the clock also holds while a fresh word settles on sdo
  assign clk_en     = (cnt != '0) && !waiting;

  // sdo3 carries the top bit of each nibble in quad mode
  assign sdo = quad ? shreg[word_w-1 -: quad_lanes] :
                      {{(quad_lanes-1){1'b0}}, shreg[word_w-1]};

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      cnt       <= '0;
      word_left <= '0;
      waiting   <= 1'b0;
      done      <= 1'b0;
    end
    else
    begin
      done <= shift && (cnt == step);
      if (load)
      begin
        cnt       <= bits;
        word_left <= len_w'(word_w);
        waiting   <= !word_valid;
      end
      else if (waiting && word_valid)
      begin
        word_left <= len_w'(word_w);
        waiting   <= 1'b0;
      end
      else if (shift)
      begin
        cnt       <= cnt - step;
        word_left <= word_left - step;
        // a drained word with bits still to go waits for the next one
        waiting   <= (word_left == step) && (cnt != step);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (word_ready && word_valid)
      shreg <= word;
    else if (shift)
      shreg <= quad ? (shreg << quad_lanes) : (shreg << 1);
  end

endmodule

/* spi_engine/spi_rx_shift.sv */
// inbound shifter, samples sdi on sclk rising strobes and hands out 32-bit words
module spi_rx_shift
  import spi_pkg::*;
(
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  load,
  input  logic [len_w-1:0]      bits,
  input  logic                  quad,
  input  logic                  rx_edge,
  input  logic [quad_lanes-1:0] sdi,
  input  logic                  data_ready,
  output logic [word_w-1:0]     data,
  output logic                  data_valid,
  output logic                  done,
  output logic                  clk_en
);

  logic [len_w-1:0] cnt;
  logic [len_w-1:0] word_left;
  logic [len_w-1:0] step;
  logic             sample;

  assign step   = quad ? len_w'(quad_lanes) : len_w'(1);
  assign sample = rx_edge && (cnt != '0) && !data_valid;
  assign clk_en = (cnt != '0) && !data_valid;

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      cnt        <= '0;
      word_left  <= '0;
      data_valid <= 1'b0;
      done       <= 1'b0;
    end
    else
    begin
      // the phase ends once the last word has been taken
      done <= data_valid && data_ready && (cnt == '0);
      if (load)
      begin
        cnt       <= bits;
        word_left <= len_w'(word_w);
      end
      else if (data_valid && data_ready)
        data_valid <= 1'b0;
      else if (sample)
      begin
        cnt        <= cnt - step;
        word_left  <= (word_left == step) ? len_w'(word_w) : word_left - step;
        data_valid <= (word_left == step) || (cnt == step);
      end
    end
  end

  // cleared per word so that a short last word comes out right aligned
  always_ff @(posedge clk)
  begin
    if (load || (data_valid && data_ready))
      data <= '0;
    else if (sample)
      data <= quad ? {data[word_w-quad_lanes-1:0], sdi} : {data[word_w-2:0], sdi[1]};
  end

endmodule

/* spi_engine/spi_fsm.sv */
// transfer sequencer, walks command, address and data phases and drives chip select and pad mode
module spi_fsm
  import spi_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,
  input  spi_req_t          req,
  input  logic              req_valid,
  input  logic [word_w-1:0] tx_data,
  input  logic              tx_valid,
  input  logic              tx_word_ready,
  input  logic              tx_done,
  input  logic              tx_clk_en,
  input  logic              rx_done,
  input  logic              rx_clk_en,
  output logic              req_ready,
  output logic              tx_ready,
  output logic              eot,
  output logic [num_cs-1:0] csn,
  output spi_mode_e         mode,
  output logic              clk_en,
  output logic [div_w-1:0]  clk_div,
  output logic              quad,
  output logic              tx_load,
  output logic [word_w-1:0] tx_word,
  output logic [len_w-1:0]  tx_bits,
  output logic              tx_word_valid,
  output logic              rx_load,
  output logic [len_w-1:0]  rx_bits
);

  spi_phase_e phase;
  spi_phase_e phase_nxt;
  spi_phase_e step_to;
  spi_phase_e data_phase;
  spi_phase_e after_cmd;
  spi_mode_e  mode_nxt;
  spi_req_t   req_q;
  spi_req_t   rq;
  logic       advance;
  logic       tx_fifo;

  // while idle the live request decides the first phase, later the latched copy
  assign rq        = (phase == ph_idle) ? req : req_q;
  assign quad      = (rq.op == op_quad_read) || (rq.op == op_quad_write);
  assign req_ready = (phase == ph_idle);
  assign clk_div   = rq.clk_div;
  assign rx_bits   = rq.data_len;

  always_comb
  begin
    if (rq.data_len == '0)
      data_phase = ph_idle;
    else if ((rq.op == op_read) || (rq.op == op_quad_read))
      data_phase = ph_data_in;
    else
      data_phase = ph_data_out;
    after_cmd = (rq.addr_len != '0) ? ph_addr : data_phase;
    advance   = 1'b0;
    step_to   = ph_idle;
    case (phase)
      ph_idle:
      begin
        advance = req_valid;
        step_to = (rq.cmd_len != '0) ? ph_cmd : after_cmd;
      end
      ph_cmd:
      begin
        advance = tx_done;
        step_to = after_cmd;
      end
      ph_addr:
      begin
        advance = tx_done;
        step_to = data_phase;
      end
      ph_data_out: advance = tx_done;
      ph_data_in:  advance = rx_done;
      default: ;
    endcase
    phase_nxt = advance ? step_to : phase;
  end

  // outbound word source, the stream is selected from the load of the data phase onwards
  always_comb
  begin
    tx_load = advance && ((step_to == ph_cmd) || (step_to == ph_addr) ||
                          (step_to == ph_data_out));
    rx_load = advance && (step_to == ph_data_in);
    tx_fifo = (phase == ph_data_out) || (advance && (step_to == ph_data_out));
    tx_word       = rq.addr;
    tx_bits       = len_w'(rq.addr_len);
    tx_word_valid = 1'b1;
    if (tx_fifo)
    begin
      tx_word       = tx_data;
      tx_bits       = rq.data_len;
      tx_word_valid = tx_valid;
    end
    else if (step_to == ph_cmd)
    begin
      tx_word = rq.cmd;
      tx_bits = len_w'(rq.cmd_len);
    end
  end

  assign tx_ready = tx_fifo && tx_word_ready;

  always_comb
  begin
    case (phase)
      ph_cmd, ph_addr, ph_data_out: clk_en = tx_clk_en;
      ph_data_in:                   clk_en = rx_clk_en;
      default:                      clk_en = 1'b0;
    endcase
    case (phase_nxt)
      ph_cmd, ph_addr, ph_data_out: mode_nxt = quad ? mode_quad_out : mode_std;
      ph_data_in:                   mode_nxt = quad ? mode_quad_in : mode_std;
      default:                      mode_nxt = mode_quad_in;
    endcase
  end

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      phase <= ph_idle;
      mode  <= mode_quad_in;
      csn   <= '1;
      eot   <= 1'b0;
    end
    else
    begin
      phase <= phase_nxt;
      mode  <= mode_nxt;
      csn   <= (phase_nxt == ph_idle) ? '1 : ~rq.cs_mask;
      eot   <= advance && (step_to == ph_idle);
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_valid && req_ready)
      req_q <= req;
  end

endmodule

/* rtl/spi_master_top.sv */
// SPI master top level, connects the phase FSM, the clock timer and both shift registers
module spi_master_top
  import spi_pkg::*;
(
  input  logic                  clk,
  input  logic                  rstn,
  input  spi_req_t              req,
  input  logic                  req_valid,
  output logic                  req_ready,
  input  logic [word_w-1:0]     tx_data,
  input  logic                  tx_valid,
  output logic                  tx_ready,
  output logic [word_w-1:0]     rx_data,
  output logic                  rx_valid,
  input  logic                  rx_ready,
  output logic                  eot,
  output logic                  sclk,
  output logic [num_cs-1:0]     csn,
  output spi_mode_e             mode,
  output logic [quad_lanes-1:0] sdo,
  input  logic [quad_lanes-1:0] sdi
);

  logic              clk_en;
  logic [div_w-1:0]  clk_div;
  logic              sclk_rise;
  logic              sclk_fall;
  logic              quad;
  logic              tx_load;
  logic [word_w-1:0] tx_word;
  logic [len_w-1:0]  tx_bits;
  logic              tx_word_valid;
  logic              tx_word_ready;
  logic              tx_done;
  logic              tx_clk_en;
  logic              rx_load;
  logic [len_w-1:0]  rx_bits;
  logic              rx_done;
  logic              rx_clk_en;

  spi_fsm u_spi_fsm (
    .clk           (clk),
    .rstn          (rstn),
    .req           (req),
    .req_valid     (req_valid),
    .tx_data       (tx_data),
    .tx_valid      (tx_valid),
    .tx_word_ready (tx_word_ready),
    .tx_done       (tx_done),
    .tx_clk_en     (tx_clk_en),
    .rx_done       (rx_done),
    .rx_clk_en     (rx_clk_en),
    .req_ready     (req_ready),
    .tx_ready      (tx_ready),
    .eot           (eot),
    .csn           (csn),
    .mode          (mode),
    .clk_en        (clk_en),
    .clk_div       (clk_div),
    .quad          (quad),
    .tx_load       (tx_load),
    .tx_word       (tx_word),
    .tx_bits       (tx_bits),
    .tx_word_valid (tx_word_valid),
    .rx_load       (rx_load),
    .rx_bits       (rx_bits)
  );

  spi_clkgen u_spi_clkgen (
    .clk       (clk),
    .rstn      (rstn),
    .en        (clk_en),
    .clk_div   (clk_div),
    .sclk      (sclk),
    .sclk_rise (sclk_rise),
    .sclk_fall (sclk_fall)
  );

  spi_tx_shift u_spi_tx_shift (
    .clk        (clk),
    .rstn       (rstn),
    .load       (tx_load),
    .bits       (tx_bits),
    .word       (tx_word),
    .word_valid (tx_word_valid),
    .quad       (quad),
    .tx_edge    (sclk_fall),
    .word_ready (tx_word_ready),
    .sdo        (sdo),
    .done       (tx_done),
    .clk_en     (tx_clk_en)
  );

  spi_rx_shift u_spi_rx_shift (
    .clk        (clk),
    .rstn       (rstn),
    .load       (rx_load),
    .bits       (rx_bits),
    .quad       (quad),
    .rx_edge    (sclk_rise),
    .sdi        (sdi),
    .data_ready (rx_ready),
    .data       (rx_data),
    .data_valid (rx_valid),
    .done       (rx_done),
    .clk_en     (rx_clk_en)
  );

endmodule

/* bench/spi_flash_model.sv */
// behavioral serial flash for the testbench, records each sclk rise and drives sdi from an LFSR
module spi_flash_model
  import spi_pkg::*;
#(
  parameter logic [15:0] seed = 16'hace1
)
(
  input  logic                  sclk,
  input  logic [num_cs-1:0]     csn,
  input  logic [quad_lanes-1:0] sdo,
  input  spi_mode_e             mode,
  output logic [quad_lanes-1:0] sdi
);

  timeunit 1ns;
  timeprecision 1ps;

  logic [15:0]           lfsr;
  logic                  cs_idle;
  logic [quad_lanes-1:0] sdo_q[$];
  logic [quad_lanes-1:0] sdi_q[$];
  spi_mode_e             mode_q[$];

  assign cs_idle = &csn;
  assign sdi     = lfsr[quad_lanes-1:0];

  initial
  begin
    lfsr = seed;
  end

  // a new transfer starts with empty records
  always @(negedge cs_idle)
  begin
    sdo_q.delete();
    sdi_q.delete();
    mode_q.delete();
  end

  // the master samples on the rise, so sdi moves on every fall
  always @(negedge sclk)
  begin
    lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
  end

  always @(posedge sclk)
  begin
    if (!cs_idle)
    begin
      sdo_q.push_back(sdo);
      sdi_q.push_back(sdi);
      mode_q.push_back(mode);
    end
  end

endmodule

/* bench/tb_spi_top.sv */
// testbench for the SPI master, runs seeded random transfers and checks them against the flash model
module tb_spi_top
  import spi_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int num_req = 24;
  localparam int max_div = 3;
  // longest transfer is 8 + 32 field bits and 128 data bits, times 3 for stream gaps
  localparam int cycles_per_req = (8 + 32 + 128) * 2 * (max_div + 1) * 3;
  localparam int cycle_limit = num_req * cycles_per_req;

  logic                  clk;
  logic                  rstn;
  spi_req_t              req;
  logic                  req_valid;
  logic                  req_ready;
  logic [word_w-1:0]     tx_data;
  logic                  tx_valid;
  logic                  tx_ready;
  logic [word_w-1:0]     rx_data;
  logic                  rx_valid;
  logic                  rx_ready;
  logic                  eot;
  logic                  sclk;
  logic [num_cs-1:0]     csn;
  spi_mode_e             mode;
  logic [quad_lanes-1:0] sdo;
  logic [quad_lanes-1:0] sdi;
  int                    cycles;
  int                    checks;
  int                    errors;

  spi_master_top u_spi_master_top (
    .clk       (clk),
    .rstn      (rstn),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .tx_data   (tx_data),
    .tx_valid  (tx_valid),
    .tx_ready  (tx_ready),
    .rx_data   (rx_data),
    .rx_valid  (rx_valid),
    .rx_ready  (rx_ready),
    .eot       (eot),
    .sclk      (sclk),
    .csn       (csn),
    .mode      (mode),
    .sdo       (sdo),
    .sdi       (sdi)
  );

  spi_flash_model u_flash (
    .sclk (sclk),
    .csn  (csn),
    .sdo  (sdo),
    .mode (mode),
    .sdi  (sdi)
  );

  always #5 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit)
    begin
      $display("the run timed out after %0d cycles", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic run_one(input int idx);
    spi_req_t          r;
    logic              exp_bits[$];
    logic [31:0]       words[$];
    logic [31:0]       pending[$];
    logic [31:0]       exp_rx[$];
    logic [31:0]       got_rx[$];
    logic [31:0]       w;
    logic [3:0]        unit;
    logic [num_cs-1:0] cs_exp;
    spi_mode_e         exp_mode;
    int                step;
    int                field_units;
    int                rises;
    int                n;
    int                errors_before;
    bit                rd;
    bit                qd;
    bit                xfer_done;
    bit                seen;
    errors_before = errors;
    r.op       = spi_op_e'(2'(idx));
    r.cmd      = $urandom;
    r.cmd_len  = ($urandom % 4 == 0) ? field_len_w'(0) : field_len_w'(8);
    r.addr     = $urandom;
    n          = int'($urandom % 4);
    r.addr_len = (n == 0) ? field_len_w'(0) : ((n == 1) ? field_len_w'(24) : field_len_w'(32));
    r.data_len = len_w'(32 * (1 + $urandom % 4));
    r.cs_mask  = num_cs'(1 + $urandom % 15);
    r.clk_div  = div_w'($urandom % (max_div + 1));
    // selected chip selects are driven low
    cs_exp = ~r.cs_mask;
    rd = (r.op == op_read) || (r.op == op_quad_read);
    qd = (r.op == op_quad_read) || (r.op == op_quad_write);
    step = qd ? 4 : 1;
    for (int i = 0; i < int'(r.cmd_len); i++)
      exp_bits.push_back(r.cmd[31-i]);
    for (int i = 0; i < int'(r.addr_len); i++)
      exp_bits.push_back(r.addr[31-i]);
    if (!rd)
    begin
      for (int k = 0; k < int'(r.data_len) / 32; k++)
      begin
        w = $urandom;
        words.push_back(w);
        for (int i = 0; i < 32; i++)
          exp_bits.push_back(w[31-i]);
      end
    end
    pending = words;
    field_units = (int'(r.cmd_len) + int'(r.addr_len)) / step;

    @(negedge clk);
    req = r;
    req_valid = 1'b1;
    @(negedge clk);
    // the controller holds its own copy, so the live request may change
    req_valid = 1'b0;
    req = '0;
    check_val("csn", 32'(csn), 32'(cs_exp));
    xfer_done = 1'b0;
    fork
      begin
        while (!xfer_done)
        begin
          tx_valid = (pending.size() > 0) && ($urandom % 4 != 0);
          tx_data  = tx_valid ? pending[0] : $urandom;
          #1;
          if (tx_valid && tx_ready)
            void'(pending.pop_front());
          @(negedge clk);
        end
        tx_valid = 1'b0;
      end
      begin
        while (!xfer_done)
        begin
          rx_ready = ($urandom % 3) != 0;
          #1;
          if (rx_valid && rx_ready)
            got_rx.push_back(rx_data);
          @(negedge clk);
        end
        rx_ready = 1'b0;
      end
      begin
        seen = 1'b0;
        while (!seen)
        begin
          @(negedge clk);
          if (eot)
            seen = 1'b1;
          else
          begin
            check_val("csn", 32'(csn), 32'(cs_exp));
            check_val("req_ready", 32'(req_ready), 32'(0));
          end
        end
        check_val("csn", 32'(csn), 32'({num_cs{1'b1}}));
        @(negedge clk);
        check_val("eot", 32'(eot), 32'(0));
        check_val("csn", 32'(csn), 32'({num_cs{1'b1}}));
        xfer_done = 1'b1;
      end
    join

    rises = u_flash.sdo_q.size();
    check_val("sclk rises", rises,
              (int'(r.cmd_len) + int'(r.addr_len) + int'(r.data_len)) / step);
    for (int i = 0; i < rises; i++)
    begin
      if (!qd)
        exp_mode = mode_std;
      else if (!rd || i < field_units)
        exp_mode = mode_quad_out;
      else
        exp_mode = mode_quad_in;
      check_val("mode", 32'(u_flash.mode_q[i]), 32'(exp_mode));
      if ((i < field_units || !rd) && (i * step + step <= exp_bits.size()))
      begin
        if (qd)
          unit = {exp_bits[4*i], exp_bits[4*i+1], exp_bits[4*i+2], exp_bits[4*i+3]};
        else
          unit = {3'b000, exp_bits[i]};
        check_val("sdo", 32'(qd ? u_flash.sdo_q[i] : {3'b000, u_flash.sdo_q[i][0]}), 32'(unit));
      end
    end
    if (rd)
    begin
      w = '0;
      n = 0;
      for (int i = field_units; i < rises; i++)
      begin
        if (qd)
          w = {w[27:0], u_flash.sdi_q[i]};
        else
          w = {w[30:0], u_flash.sdi_q[i][1]};
        n = n + step;
        if (n == 32)
        begin
          exp_rx.push_back(w);
          w = '0;
          n = 0;
        end
      end
      if (n > 0)
        exp_rx.push_back(w);
      check_val("rx word count", got_rx.size(), exp_rx.size());
      for (int i = 0; i < exp_rx.size() && i < got_rx.size(); i++)
        check_val("rx_data", got_rx[i], exp_rx[i]);
    end
    else
      check_val("tx words left", pending.size(), 0);
    $display("test %0d op %0d cmd_len %0d addr_len %0d data_len %0d div %0d: %s", idx,
             r.op, r.cmd_len, r.addr_len, r.data_len, r.clk_div,
             (errors == errors_before) ? "ok" : "mismatch");
  endtask

  initial
  begin
    clk       = 1'b0;
    rstn      = 1'b0;
    req       = '0;
    req_valid = 1'b0;
    tx_data   = '0;
    tx_valid  = 1'b0;
    rx_ready  = 1'b0;
    cycles    = 0;
    checks    = 0;
    errors    = 0;
    void'($urandom(34));
    repeat (5) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    check_val("csn", 32'(csn), 32'({num_cs{1'b1}}));
    check_val("req_ready", 32'(req_ready), 32'(1));
    check_val("mode", 32'(mode), 32'(mode_quad_in));
    check_val("sclk", 32'(sclk), 32'(0));
    check_val("eot", 32'(eot), 32'(0));
    check_val("tx_ready", 32'(tx_ready), 32'(0));
    check_val("rx_valid", 32'(rx_valid), 32'(0));
    for (int i = 0; i < num_req; i++)
      run_one(i);
    $display("%0d transfers, %0d checks, %0d errors", num_req, checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

/* vlog.f */
common/spi_pkg.sv
rtl/spi_clkgen.sv
spi_engine/spi_tx_shift.sv
spi_engine/spi_rx_shift.sv
spi_engine/spi_fsm.sv
rtl/spi_master_top.sv
bench/spi_flash_model.sv
bench/tb_spi_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the SPI master testbench with Verilator, runs it and checks the log for the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_spi_top --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
